//--- Bender.yml
package:
  name: fifo_ctrl_1r1w

export_include_dirs:
  - include

sources:
  # Packages first, then blocks, then the top level
  - files:
      - rtl/fifo_cfg_pkg.sv
      - rtl/fifo_ram_pkg.sv
      - rtl/fifo_push_ctrl.sv
      - rtl/fifo_ram_1r1w.sv
      - rtl/fifo_pop_ctrl.sv
      - rtl/fifo_ctrl_1r1w.sv

  - target: test
    files:
      - test/fifo_tb.sv

//--- flist.f
+incdir+include
rtl/fifo_cfg_pkg.sv
rtl/fifo_ram_pkg.sv
rtl/fifo_push_ctrl.sv
rtl/fifo_ram_1r1w.sv
rtl/fifo_pop_ctrl.sv
rtl/fifo_ctrl_1r1w.sv
test/fifo_tb.sv

//--- include/fifo_assert.svh
`ifndef FIFO_ASSERT_SVH
`define FIFO_ASSERT_SVH

// ----------------------------------------------------------------------
// Assertion helpers for the FIFO blocks
// ----------------------------------------------------------------------

// Concurrent check on the module clock
// Held off while rst_n is low
// Expects clk and rst_n in the enclosing module
`define FIFO_ASSERT(name, prop) \
  name : assert property (@(posedge clk) disable iff (!rst_n) (prop)) \
    else $error("%m: concurrent check failed");

// Elaboration-time check on parameters
// Becomes an empty generate branch when the condition holds
`define FIFO_ASSERT_STATIC(name, cond) \
  if (!(cond)) begin : name \
    $error("%m: parameter check failed"); \
  end

// Checks are grouped per module
// Integration checks guard the ports
// Implementation checks guard internal state

`endif

//--- rtl/fifo_cfg_pkg.sv
`default_nettype none

package fifo_cfg_pkg;

  // Default geometry, overridden from the top level
  localparam int DefaultDepth = 8;
  localparam int DefaultBitWidth = 16;

  // Wrap and bypass logic need at least two entries
  localparam int MinDepth = 2;

  // Width rules
  // Index into an array of depth entries, never zero wide
  function automatic int addr_width(int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

  // Occupancy counter holds 0 to depth inclusive
  function automatic int count_width(int depth);
    return $clog2(depth + 1);
  endfunction

endpackage : fifo_cfg_pkg

`default_nettype wire

//--- rtl/fifo_ctrl_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl_1r1w #(
  parameter int Depth = fifo_cfg_pkg::DefaultDepth,
  parameter int BitWidth = fifo_cfg_pkg::DefaultBitWidth,
  parameter bit EnableBypass = 1'b1,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width(Depth)
) (
  input wire logic clk,
  input wire logic rst_n,

  // Push port
  output logic push_ready,
  input wire logic push_valid,
  input wire logic [BitWidth-1:0] push_data,

  // Pop port
  output logic pop_valid,
  input wire logic pop_ready,
  output logic [BitWidth-1:0] pop_data,

  // Status
  output logic full,
  output logic [CountWidth-1:0] slots,
  output logic [CountWidth-1:0] items
);

  // ----------------------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------------------
  // Bypass path
  logic bypass_ready;
  logic bypass_valid;
  logic [BitWidth-1:0] bypass_data;

  // Array ports
  logic ram_wr_valid;
  logic [AddrWidth-1:0] ram_wr_addr;
  logic [BitWidth-1:0] ram_wr_data;
  logic ram_rd_valid;
  logic [AddrWidth-1:0] ram_rd_addr;
  logic ram_rd_data_valid;
  logic [BitWidth-1:0] ram_rd_data;

  // Write and read events between the controllers
  logic ram_push;
  logic ram_pop;

  // ----------------------------------------------------------------------
  // Push side, storage, pop side
  // ----------------------------------------------------------------------
  fifo_push_ctrl #(
    .Depth(Depth),
    .BitWidth(BitWidth),
    .EnableBypass(EnableBypass)
  ) push_ctrl_i (
    .clk(clk),
    .rst_n(rst_n),
    .push_ready(push_ready),
    .push_valid(push_valid),
    .push_data(push_data),
    .full(full),
    .slots(slots),
    .bypass_ready(bypass_ready),
    .bypass_valid(bypass_valid),
    .bypass_data(bypass_data),
    .ram_wr_valid(ram_wr_valid),
    .ram_wr_addr(ram_wr_addr),
    .ram_wr_data(ram_wr_data),
    .ram_push(ram_push),
    .ram_pop(ram_pop)
  );

  fifo_ram_1r1w #(
    .Depth(Depth),
    .BitWidth(BitWidth)
  ) ram_i (
    .clk(clk),
    .rst_n(rst_n),
    .wr_valid(ram_wr_valid),
    .wr_addr(ram_wr_addr),
    .wr_data(ram_wr_data),
    .rd_valid(ram_rd_valid),
    .rd_addr(ram_rd_addr),
    .rd_data_valid(ram_rd_data_valid),
    .rd_data(ram_rd_data)
  );

  fifo_pop_ctrl #(
    .Depth(Depth),
    .BitWidth(BitWidth),
    .EnableBypass(EnableBypass)
  ) pop_ctrl_i (
    .clk(clk),
    .rst_n(rst_n),
    .ram_push(ram_push),
    .ram_pop(ram_pop),
    .ram_rd_valid(ram_rd_valid),
    .ram_rd_addr(ram_rd_addr),
    .ram_rd_data_valid(ram_rd_data_valid),
    .ram_rd_data(ram_rd_data),
    .bypass_ready(bypass_ready),
    .bypass_valid(bypass_valid),
    .bypass_data(bypass_data),
    .pop_valid(pop_valid),
    .pop_data(pop_data),
    .pop_ready(pop_ready),
    .items(items)
  );

endmodule : fifo_ctrl_1r1w

`default_nettype wire

//--- rtl/fifo_pop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_assert.svh"

module fifo_pop_ctrl #(
  parameter int Depth = fifo_cfg_pkg::DefaultDepth,
  parameter int BitWidth = fifo_cfg_pkg::DefaultBitWidth,
  parameter bit EnableBypass = 1'b1,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width(Depth)
) (
  input wire logic clk,
  input wire logic rst_n,

  // Array write event from push controller
  input wire logic ram_push,

  // Array read port, ram_pop marks the same event for the push side
  output logic ram_pop,
  output logic ram_rd_valid,
  output logic [AddrWidth-1:0] ram_rd_addr,
  input wire logic ram_rd_data_valid,
  input wire logic [BitWidth-1:0] ram_rd_data,

  // Bypass from push controller
  output logic bypass_ready,
  input wire logic bypass_valid,
  input wire logic [BitWidth-1:0] bypass_data,

  // Pop port, driven from the output register
  output logic pop_valid,
  output logic [BitWidth-1:0] pop_data,
  input wire logic pop_ready,

  // Items held in the array
  output logic [CountWidth-1:0] items
);

  import fifo_cfg_pkg::*;
  import fifo_ram_pkg::*;

  localparam logic [CountWidth-1:0] DepthCount = CountWidth'(Depth);
  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(Depth - 1);

  `FIFO_ASSERT_STATIC(depth_min_a, Depth >= MinDepth)
  `FIFO_ASSERT_STATIC(read_latency_min_a, RamReadLatency >= 1)

  // One bit per read stage, oldest at the top
  logic [RamReadLatency-1:0] rd_pending;
  logic rd_inflight;
  logic out_free;
  logic load_bypass;
  logic load;
  logic [CountWidth-1:0] items_next;

  // ----------------------------------------------------------------------
  // Read issue
  // ----------------------------------------------------------------------
  // Register empty now or emptied by this cycle's pop
  assign out_free = !pop_valid || pop_ready;
  assign rd_inflight = |rd_pending;

  // Data lands one cycle after issue, register must be free by then
  assign ram_rd_valid = (items != '0) && !rd_inflight && out_free;
  assign ram_pop = ram_rd_valid;

  // Read pipeline tracker
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= '0;
    end else begin
      rd_pending <= RamReadLatency'({rd_pending, ram_rd_valid});
    end
  end

  // Read pointer, wraps at Depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_rd_addr <= '0;
    end else if (ram_rd_valid) begin
      ram_rd_addr <= (ram_rd_addr == LastAddr) ? '0 : ram_rd_addr + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Array item count
  // ----------------------------------------------------------------------
  always_comb begin
    items_next = items;
    if (ram_push && !ram_pop) begin
      items_next = items + 1'b1;
    end else if (!ram_push && ram_pop) begin
      items_next = items - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

  // ----------------------------------------------------------------------
  // Bypass and output register
  // ----------------------------------------------------------------------
  if (EnableBypass) begin : gen_bypass
    // Nothing stored or in flight that a bypassed item could overtake
    assign bypass_ready = out_free && (items == '0) && !rd_inflight;
    assign load_bypass = bypass_valid;
  end else begin : gen_no_bypass
    assign bypass_ready = 1'b0;
    assign load_bypass = 1'b0;
  end

  assign load = ram_rd_data_valid || load_bypass;

  // Valid flag, a load wins over a drain in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else if (load) begin
      pop_valid <= 1'b1;
    end else if (pop_ready) begin
      pop_valid <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (load) begin
      pop_data <= ram_rd_data_valid ? ram_rd_data : bypass_data;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Bypass only offered with the read pipe idle
  `FIFO_ASSERT(no_double_load_a, !(ram_rd_data_valid && bypass_valid))
  `FIFO_ASSERT(items_in_range_a, items <= DepthCount)
  // Stalled output keeps its item
  `FIFO_ASSERT(pop_hold_a, pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))

endmodule : fifo_pop_ctrl

`default_nettype wire

//--- rtl/fifo_push_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_assert.svh"

module fifo_push_ctrl #(
  parameter int Depth = fifo_cfg_pkg::DefaultDepth,
  parameter int BitWidth = fifo_cfg_pkg::DefaultBitWidth,
  parameter bit EnableBypass = 1'b1,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width(Depth)
) (
  input wire logic clk,
  input wire logic rst_n,

  // Push port
  output logic push_ready,
  input wire logic push_valid,
  input wire logic [BitWidth-1:0] push_data,

  // Push-side status
  output logic full,
  output logic [CountWidth-1:0] slots,

  // Bypass to pop controller
  input wire logic bypass_ready,
  output logic bypass_valid,
  output logic [BitWidth-1:0] bypass_data,

  // Array write port
  output logic ram_wr_valid,
  output logic [AddrWidth-1:0] ram_wr_addr,
  output logic [BitWidth-1:0] ram_wr_data,
  // Array write event to pop controller
  output logic ram_push,

  // Array read event from pop controller
  // Never raised for bypassed items
  input wire logic ram_pop
);

  import fifo_cfg_pkg::*;

  // Full count of free slots
  localparam logic [CountWidth-1:0] DepthCount = CountWidth'(Depth);
  // Last legal write address
  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(Depth - 1);

  // ----------------------------------------------------------------------
  // Parameter and port checks
  // ----------------------------------------------------------------------
  `FIFO_ASSERT_STATIC(depth_min_a, Depth >= MinDepth)
  `FIFO_ASSERT_STATIC(bit_width_min_a, BitWidth >= 1)

  // Sender keeps the item steady while stalled
  `FIFO_ASSERT(push_hold_a, push_valid && !push_ready |=> push_valid && $stable(push_data))

  // Pop side cannot free a slot that was never filled
  `FIFO_ASSERT(no_pop_when_empty_a, slots == DepthCount |-> !ram_pop)

  logic push;
  logic [CountWidth-1:0] slots_next;

  // ----------------------------------------------------------------------
  // Flow control and steering
  // ----------------------------------------------------------------------
  assign push_ready = !full;
  assign push = push_valid && push_ready;

  if (EnableBypass) begin : gen_bypass
    // Pop side free and array empty so the item skips storage
    assign bypass_valid = push && bypass_ready;
    assign bypass_data = push_data;
    assign ram_push = push && !bypass_ready;
  end else begin : gen_no_bypass
    // Every item goes through the array
    assign bypass_valid = 1'b0;
    assign bypass_data = '0;
    assign ram_push = push;
  end

  // Array write side
  assign ram_wr_valid = ram_push;
  assign ram_wr_data = push_data;

  // Write pointer wrapping at Depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_wr_addr <= '0;
    end else if (ram_push) begin
      ram_wr_addr <= (ram_wr_addr == LastAddr) ? '0 : ram_wr_addr + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Free-slot count and full flag
  // ----------------------------------------------------------------------
  // Write takes a slot and an array pop gives one back
  always_comb begin
    slots_next = slots;
    if (ram_push && !ram_pop) begin
      slots_next = slots - 1'b1;
    end else if (!ram_push && ram_pop) begin
      slots_next = slots + 1'b1;
    end
  end

  // Both registered so push_ready returns the cycle after a pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slots <= DepthCount;
      full <= 1'b0;
    end else begin
      slots <= slots_next;
      full <= (slots_next == '0);
    end
  end

  // ----------------------------------------------------------------------
  // Status checks
  // ----------------------------------------------------------------------
  `FIFO_ASSERT(slots_in_range_a, slots <= DepthCount)
  // Last free slot written and nothing read back
  // Count hits zero and the flag rises one cycle later
  `FIFO_ASSERT(full_matches_slots_a,
               slots == CountWidth'(1) && ram_push && !ram_pop |=> full && slots == '0)

endmodule : fifo_push_ctrl

`default_nettype wire

//--- rtl/fifo_ram_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_assert.svh"

module fifo_ram_1r1w #(
  parameter int Depth = fifo_cfg_pkg::DefaultDepth,
  parameter int BitWidth = fifo_cfg_pkg::DefaultBitWidth,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width(Depth)
) (
  input wire logic clk,
  input wire logic rst_n,

  // Write port
  input wire logic wr_valid,
  input wire logic [AddrWidth-1:0] wr_addr,
  input wire logic [BitWidth-1:0] wr_data,

  // Read port, data one cycle after the request
  input wire logic rd_valid,
  input wire logic [AddrWidth-1:0] rd_addr,
  output logic rd_data_valid,
  output logic [BitWidth-1:0] rd_data
);

  import fifo_ram_pkg::*;

  // Single read register stage below
  `FIFO_ASSERT_STATIC(read_latency_is_one_a, RamReadLatency == 1)

  logic [BitWidth-1:0] mem [Depth];

  // Storage
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data register
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_valid;
    end
  end

  // Controllers wrap at Depth
  `FIFO_ASSERT(wr_addr_in_range_a, wr_valid |-> wr_addr < Depth)
  `FIFO_ASSERT(rd_addr_in_range_a, rd_valid |-> rd_addr < Depth)

endmodule : fifo_ram_1r1w

`default_nettype wire

//--- rtl/fifo_ram_pkg.sv
`default_nettype none

package fifo_ram_pkg;

  // Storage array access timing
  // Cycles from rd_valid to rd_data_valid
  // Read port is a single register stage
  localparam int RamReadLatency = 1;

  // Write is registered on the same edge as the address
  // so a read issued next cycle already sees it

endpackage : fifo_ram_pkg

`default_nettype wire

//--- test/fifo_patterns.txt
# S push_valid pop_ready push_data(hex)       one clock cycle
# P push_data(hex)                            bypass probe, push with pop_ready high
# W cycles                                    idle, push_valid low, pop_ready high
# R cycles pop_weight                         LFSR phase, pop_ready when 3 bits < weight
# C slots items full push_ready queued        checkpoint after the cycles above

# Reset state
C 8 0 0 1 0

# Single push straight through the bypass
P a5a5
W 3
C 8 0 0 1 0

# Fill with the pop side stalled, first item sits in the output register
S 1 0 1001
S 1 0 1002
S 1 0 1003
S 1 0 1004
S 1 0 1005
S 1 0 1006
S 1 0 1007
S 1 0 1008
S 1 0 1009
C 0 8 1 0 9

# One pop, then the read lands and push_ready is back
S 0 1 0000
S 0 0 0000
C 1 7 0 1 8
S 1 0 100a
C 0 8 1 0 9
W 24
C 8 0 0 1 0

# Pushes and pops in the same cycles
S 1 1 2001
S 1 1 2002
S 1 1 2003
S 1 0 2004
S 0 1 0000
S 1 1 2005
W 8
C 8 0 0 1 0

# Random phases, mostly filling then mostly draining
R 300 2
R 300 6
W 30
C 8 0 0 1 0

//--- test/fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_tb;

  localparam int Depth = 8;
  localparam int BitWidth = 16;
  localparam int CountWidth = $clog2(Depth + 1);
  localparam int ResetCycles = 16;
  localparam logic [15:0] LfsrSeed = 16'd40398;
  // Feedback taps for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LfsrTaps = 16'hB400;

  // One parsed line of the pattern file
  typedef struct packed {
    logic [7:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
  } pattern_t;

  logic clk;
  logic rst_n;
  logic push_ready;
  logic push_valid;
  logic [BitWidth-1:0] push_data;
  logic pop_valid;
  logic pop_ready;
  logic [BitWidth-1:0] pop_data;
  logic full;
  logic [CountWidth-1:0] slots;
  logic [CountWidth-1:0] items;

  pattern_t pat_q[$];
  // Reference model, head is the next item due at the pop port
  logic [BitWidth-1:0] model_q[$];
  logic [15:0] lfsr_state = LfsrSeed;
  logic push_stalled = 1'b0;
  int total_cycles = 0;
  int cycle_limit = 0;
  int cycle_count = 0;
  int checks = 0;
  int errors = 0;

  fifo_ctrl_1r1w #(
    .Depth(Depth),
    .BitWidth(BitWidth),
    .EnableBypass(1'b1)
  ) dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .push_ready(push_ready),
    .push_valid(push_valid),
    .push_data(push_data),
    .pop_valid(pop_valid),
    .pop_ready(pop_ready),
    .pop_data(pop_data),
    .full(full),
    .slots(slots),
    .items(items)
  );

  // ----------------------------------------------------------------------
  // Clock and watchdog
  // ----------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Limit known once the pattern file is parsed
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      errors = errors + 1;
      $display("timeout after %0d cycles, the patterns did not complete", cycle_count);
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ LfsrTaps;
    end
    return shifted;
  endfunction

  // One LFSR step per bit, first bit taken lands in bit 0
  task automatic draw_bits(input int n, output logic [15:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Inputs already driven, handshakes sampled mid-cycle, returns 1 ns after the edge
  task automatic step_cycle();
    logic [BitWidth-1:0] head;
    @(negedge clk);
    if (pop_valid && pop_ready) begin
      checks++;
      assert (model_q.size() != 0) else begin
        $display("item popped while the reference queue was empty");
        errors++;
      end
      if (model_q.size() != 0) begin
        head = model_q.pop_front();
        check_value("pop_data", pop_data, head);
      end
    end
    if (push_valid && push_ready) begin
      model_q.push_back(push_data);
    end
    // Sender must repeat a refused item
    push_stalled = push_valid && !push_ready;
    @(posedge clk);
    #1;
  endtask

  // ----------------------------------------------------------------------
  // Pattern file
  // ----------------------------------------------------------------------
  task automatic load_patterns();
    int fd;
    int a;
    int b;
    int c;
    int d;
    int e;
    bit ok;
    string line;
    logic [7:0] tag;
    pattern_t p;
    fd = $fopen("test/fifo_patterns.txt", "r");
    checks++;
    assert (fd != 0) else begin
      $display("pattern file test/fifo_patterns.txt could not be opened");
      errors++;
    end
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        tag = line.getc(0);
        // Blank and comment lines
        if (line.len() >= 2 && tag != "#") begin
          a = 0;
          b = 0;
          c = 0;
          d = 0;
          e = 0;
          case (tag)
            "S": ok = ($sscanf(line, "%c %d %d %h", tag, a, b, c) == 4);
            "P": ok = ($sscanf(line, "%c %h", tag, a) == 2);
            "W": ok = ($sscanf(line, "%c %d", tag, a) == 2);
            "R": ok = ($sscanf(line, "%c %d %d", tag, a, b) == 3);
            "C": ok = ($sscanf(line, "%c %d %d %d %d %d", tag, a, b, c, d, e) == 6);
            default: ok = 1'b0;
          endcase
          assert (ok) else begin
            $display("pattern line not understood: %s", line);
            errors++;
          end
          if (ok) begin
            p = {tag, a, b, c, d, e};
            pat_q.push_back(p);
            // Cycle budget for the watchdog
            if (tag == "S" || tag == "P") begin
              total_cycles += 1;
            end else if (tag == "W" || tag == "R") begin
              total_cycles += a;
            end
          end
        end
      end
      $fclose(fd);
      assert (pat_q.size() != 0) else begin
        $display("pattern file holds no pattern lines");
        errors++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Test phases
  // ----------------------------------------------------------------------
  task automatic check_reset_state();
    check_value("push_ready", push_ready, 1);
    check_value("pop_valid", pop_valid, 0);
    check_value("full", full, 0);
    check_value("slots", slots, Depth);
    check_value("items", items, 0);
  endtask

  // Empty idle FIFO, item due at the pop port one cycle later
  task automatic probe_bypass(input logic [BitWidth-1:0] data);
    push_valid = 1'b1;
    pop_ready = 1'b1;
    push_data = data;
    step_cycle();
    check_value("pop_valid", pop_valid, 1);
    check_value("pop_data", pop_data, data);
    check_value("slots", slots, Depth);
    push_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    push_valid = 1'b0;
    pop_ready = 1'b1;
    repeat (n) step_cycle();
  endtask

  // pop_ready high when three LFSR bits fall below the weight
  task automatic random_phase(input int n, input int weight);
    logic [15:0] bits;
    repeat (n) begin
      if (!push_stalled) begin
        draw_bits(1, bits);
        push_valid = bits[0];
        draw_bits(BitWidth, bits);
        push_data = bits;
      end
      draw_bits(3, bits);
      pop_ready = (bits[2:0] < weight);
      step_cycle();
    end
    // A refused push stays up until taken
    while (push_stalled) begin
      pop_ready = 1'b1;
      step_cycle();
    end
  endtask

  // Array items are the queue minus the item in the output register
  task automatic check_occupancy(input pattern_t p);
    int array_items;
    array_items = model_q.size() - (pop_valid ? 1 : 0);
    check_value("slots", slots, p.a);
    check_value("items", items, p.b);
    check_value("full", full, p.c);
    check_value("push_ready", push_ready, p.d);
    check_value("queued items", model_q.size(), p.e);
    check_value("slots from model", slots, Depth - array_items);
    check_value("items from model", items, array_items);
  endtask

  task automatic run_patterns();
    pattern_t p;
    foreach (pat_q[i]) begin
      p = pat_q[i];
      case (p.op)
        "S": begin
          push_valid = p.a[0];
          pop_ready = p.b[0];
          push_data = p.c[BitWidth-1:0];
          step_cycle();
        end
        "P": probe_bypass(p.a[BitWidth-1:0]);
        "W": idle_cycles(p.a);
        "R": random_phase(p.a, p.b);
        "C": check_occupancy(p);
        default: ;
      endcase
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    rst_n = 1'b0;
    load_patterns();
    cycle_limit = 4 * total_cycles + 200;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_reset_state();
    run_patterns();
    finish_run();
  end

endmodule : fifo_tb

`default_nettype wire
